// ==== bench/dispatch_core_sva.sv ====
`timescale 1ns/10ps
`default_nettype none

module dispatch_core_sva (
    input wire clk,
    input wire rst_n,
    input wire flush,
    input wire rob_full,
    input wire in_valid,
    input wire in_ready,
    input wire rs_issue_valid,
    input wire lsb_issue_valid
);
    int fail_count = 0;

    // an instruction goes to one port only
    one_issue_port: assert property (@(posedge clk) disable iff (!rst_n)
        !(rs_issue_valid && lsb_issue_valid))
        else begin
            fail_count++;
            $error("rs and lsb issue valid are high together");
        end

    // an issue always follows a decode transfer, also right after reset
    quiet_without_transfer: assert property (@(posedge clk) disable iff (!rst_n)
        !(in_valid && in_ready) |=> !rs_issue_valid && !lsb_issue_valid)
        else begin
            fail_count++;
            $error("issue valid is high without a decode transfer before it");
        end

    // the flushed cycle must not issue
    quiet_after_flush: assert property (@(posedge clk) disable iff (!rst_n)
        flush |=> !rs_issue_valid && !lsb_issue_valid)
        else begin
            fail_count++;
            $error("issue valid is high in the cycle after flush");
        end

    stall_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        rob_full |=> !rs_issue_valid && !lsb_issue_valid)
        else begin
            fail_count++;
            $error("an instruction issued while the ROB was full");
        end

endmodule

bind dispatcher dispatch_core_sva sva_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .flush           (flush),
    .rob_full        (rob_full),
    .in_valid        (in_valid),
    .in_ready        (in_ready),
    .rs_issue_valid  (rs_issue_valid),
    .lsb_issue_valid (lsb_issue_valid)
);

`default_nettype wire

// ==== bench/dispatch_core_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module dispatch_core_tb;
    import ooo_cfg_pkg::*;
    import dispatch_types_pkg::*;

    logic           clk;
    logic           rst_n;
    logic           in_valid;
    logic           flush;
    decoded_instr_t in_instr;
    cdb_t           alu_cdb;
    cdb_t           mem_cdb;
    logic           in_ready;
    logic           rs_issue_valid;
    logic           lsb_issue_valid;
    issue_pkt_t     rs_issue;
    issue_pkt_t     lsb_issue;
    commit_t        commit;

    // reference model state
    logic [xlen-1:0]      m_val  [reg_count];
    logic [rob_id_w-1:0]  m_tag  [reg_count];
    logic                 m_done [rob_depth];
    logic [xlen-1:0]      m_data [rob_depth];
    logic [reg_idx_w-1:0] m_rd   [rob_depth];
    logic [rob_id_w-1:0]  rob_q  [$];
    logic [rob_id_w-1:0]  next_id;

    bit         exp_rs;
    bit         exp_lsb;
    issue_pkt_t exp_pkt;
    integer     seed = 82;
    int         accepted;
    int         quiet;
    bit         seen_full;

    dispatch_core dut_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .in_valid        (in_valid),
        .in_instr        (in_instr),
        .alu_cdb         (alu_cdb),
        .mem_cdb         (mem_cdb),
        .flush           (flush),
        .in_ready        (in_ready),
        .rs_issue_valid  (rs_issue_valid),
        .rs_issue        (rs_issue),
        .lsb_issue_valid (lsb_issue_valid),
        .lsb_issue       (lsb_issue),
        .commit          (commit)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            fail_now($sformatf("Mismatch in %s: expected 0x%0h, actual 0x%0h",
                               name, expected, actual));
        end
    endtask

    task automatic compare_pkt(input string port, input issue_pkt_t exp, input issue_pkt_t act);
        check_value({"routing ", port, " opcode"}, exp.opcode, act.opcode);
        check_value({"routing ", port, " imm"}, exp.imm, act.imm);
        check_value({"routing ", port, " pc"}, exp.pc, act.pc);
        check_value({"routing ", port, " rob_id"}, exp.rob_id, act.rob_id);
        check_value({"forwarding ", port, " v1"}, exp.v1, act.v1);
        check_value({"forwarding ", port, " q1"}, exp.q1, act.q1);
        check_value({"forwarding ", port, " v2"}, exp.v2, act.v2);
        check_value({"forwarding ", port, " q2"}, exp.q2, act.q2);
    endtask

    function automatic int urand(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    // alu beat, then mem beat, then a finished entry, else the table as is
    function automatic void resolve_operand(input logic [reg_idx_w-1:0] rs,
                                            output logic [xlen-1:0] v,
                                            output logic [rob_id_w-1:0] q);
        logic [rob_id_w-1:0] tag;
        tag = m_tag[rs];
        v = m_val[rs];
        q = tag;
        if (tag != zero_rob) begin
            if (alu_cdb.valid && alu_cdb.rob_id == tag) begin
                v = alu_cdb.data;
                q = zero_rob;
            end else if (mem_cdb.valid && mem_cdb.rob_id == tag) begin
                v = mem_cdb.data;
                q = zero_rob;
            end else if (m_done[tag]) begin
                v = m_data[tag];
                q = zero_rob;
            end
        end
    endfunction

    task automatic drive_inputs(input bit feed);
        logic [rob_id_w-1:0] open_ids [$];
        int r;
        int pick;
        foreach (rob_q[i]) begin
            if (!m_done[rob_q[i]]) open_ids.push_back(rob_q[i]);
        end
        flush    = feed && (urand(160) == 0);
        in_valid = feed && (urand(10) < 7);
        r = urand(100);
        if (r < 4) in_instr.opcode = op_nop;
        else if (r < 24) in_instr.opcode = op_lb + opcode_w'(urand(6));
        else in_instr.opcode = op_add + opcode_w'(urand(8));
        // few registers so that dependencies are common
        in_instr.rd  = reg_idx_w'(urand(6));
        in_instr.rs1 = reg_idx_w'(urand(6));
        in_instr.rs2 = reg_idx_w'(urand(6));
        in_instr.imm = $random(seed);
        in_instr.pc  = $random(seed);
        alu_cdb = '0;
        mem_cdb = '0;
        // quiet stretches let the ROB fill up
        if (quiet > 0) quiet--;
        else if (urand(250) == 0) quiet = 30;
        if (quiet == 0 && open_ids.size() > 0 && urand(10) < 4) begin
            pick = urand(open_ids.size());
            alu_cdb = '{valid: 1'b1, rob_id: open_ids[pick], data: $random(seed)};
            open_ids.delete(pick);
        end
        if (quiet == 0 && open_ids.size() > 0 && urand(10) < 3) begin
            pick = urand(open_ids.size());
            mem_cdb = '{valid: 1'b1, rob_id: open_ids[pick], data: $random(seed)};
        end
    endtask

    task automatic update_model(input commit_t cm, input bit take);
        if (cm.valid && cm.rd != '0) m_val[cm.rd] = cm.data;
        if (flush) begin
            foreach (m_tag[i]) m_tag[i] = zero_rob;
            foreach (m_done[i]) m_done[i] = 1'b0;
            rob_q = {};
            next_id = rob_id_w'(1);
        end else begin
            if (alu_cdb.valid) begin
                m_done[alu_cdb.rob_id] = 1'b1;
                m_data[alu_cdb.rob_id] = alu_cdb.data;
            end
            if (mem_cdb.valid) begin
                m_done[mem_cdb.rob_id] = 1'b1;
                m_data[mem_cdb.rob_id] = mem_cdb.data;
            end
            if (cm.valid) begin
                if (m_tag[cm.rd] == cm.rob_id) m_tag[cm.rd] = zero_rob;
                m_done[cm.rob_id] = 1'b0;
                void'(rob_q.pop_front());
            end
            if (take) begin
                if (in_instr.rd != '0) m_tag[in_instr.rd] = next_id;
                m_rd[next_id] = in_instr.rd;
                m_done[next_id] = 1'b0;
                rob_q.push_back(next_id);
                next_id = (next_id == rob_depth - 1) ? rob_id_w'(1) : next_id + 1'b1;
            end
        end
    endtask

    task automatic run_cycle(input bit feed);
        commit_t    exp_commit;
        issue_pkt_t pkt;
        bit         full;
        bit         take;
        @(negedge clk);
        check_value("routing rs valid", exp_rs, rs_issue_valid);
        check_value("routing lsb valid", exp_lsb, lsb_issue_valid);
        if (exp_rs) compare_pkt("rs", exp_pkt, rs_issue);
        if (exp_lsb) compare_pkt("lsb", exp_pkt, lsb_issue);
        if (dut_i.dispatcher_i.sva_i.fail_count != 0) begin
            fail_now("an assertion in the dispatcher failed");
        end
        drive_inputs(feed);
        #2;
        full = (rob_q.size() == rob_depth - 1);
        if (full) seen_full = 1'b1;
        check_value("back-pressure in_ready", !full && !flush, in_ready);
        exp_commit = '0;
        if (rob_q.size() > 0 && m_done[rob_q[0]]) begin
            exp_commit = '{valid: 1'b1, rd: m_rd[rob_q[0]], data: m_data[rob_q[0]],
                           rob_id: rob_q[0]};
        end
        check_value("commit valid", exp_commit.valid, commit.valid);
        if (exp_commit.valid) begin
            check_value("commit rd", exp_commit.rd, commit.rd);
            check_value("commit data", exp_commit.data, commit.data);
            check_value("commit rob_id", exp_commit.rob_id, commit.rob_id);
        end
        if (in_valid && !full && !flush) accepted++;
        take = in_valid && !full && !flush && (in_instr.opcode != op_nop);
        exp_rs  = 1'b0;
        exp_lsb = 1'b0;
        if (take) begin
            pkt.opcode = in_instr.opcode;
            pkt.imm    = in_instr.imm;
            pkt.pc     = in_instr.pc;
            pkt.rob_id = next_id;
            resolve_operand(in_instr.rs1, pkt.v1, pkt.q1);
            resolve_operand(in_instr.rs2, pkt.v2, pkt.q2);
            exp_lsb = (in_instr.opcode >= op_lb) && (in_instr.opcode <= op_sw);
            exp_rs  = !exp_lsb;
            exp_pkt = pkt;
        end
        update_model(exp_commit, take);
    endtask

    initial begin
        int guard;
        rst_n    = 1'b0;
        in_valid = 1'b0;
        flush    = 1'b0;
        in_instr = '0;
        alu_cdb  = '0;
        mem_cdb  = '0;
        foreach (m_val[i]) m_val[i] = '0;
        foreach (m_tag[i]) m_tag[i] = zero_rob;
        foreach (m_done[i]) m_done[i] = 1'b0;
        next_id = rob_id_w'(1);
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        #1;
        check_value("reset in_ready", 1'b1, in_ready);
        check_value("reset commit valid", 1'b0, commit.valid);

        guard = 0;
        while (accepted < 2000) begin
            run_cycle(1'b1);
            guard++;
            if (guard > 20000) fail_now("timed out before 2000 instructions were accepted");
        end
        // no new work, let every entry complete and retire
        guard = 0;
        while (rob_q.size() != 0 || exp_rs || exp_lsb) begin
            run_cycle(1'b0);
            guard++;
            if (guard > 1000) fail_now("timed out while draining the ROB");
        end

        if (!seen_full) begin
            fail_now("the ROB never reached the full state");
        end else if (dut_i.dispatcher_i.sva_i.fail_count != 0) begin
            fail_now("an assertion in the dispatcher failed");
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== build.f ====
design/ooo_cfg_pkg.sv
design/dispatch_types_pkg.sv
design/reg_status_table.sv
design/rob_tracker.sv
design/dispatcher.sv
design/dispatch_core.sv
bench/dispatch_core_sva.sv
bench/dispatch_core_tb.sv

// ==== design/dispatch_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module dispatch_core (
    input  wire                                 clk,
    input  wire                                 rst_n,
    input  wire                                 in_valid,
    input  wire  dispatch_types_pkg::decoded_instr_t in_instr,
    input  wire  dispatch_types_pkg::cdb_t      alu_cdb,
    input  wire  dispatch_types_pkg::cdb_t      mem_cdb,
    input  wire                                 flush,
    output logic                                in_ready,
    output logic                                rs_issue_valid,
    output dispatch_types_pkg::issue_pkt_t      rs_issue,
    output logic                                lsb_issue_valid,
    output dispatch_types_pkg::issue_pkt_t      lsb_issue,
    output dispatch_types_pkg::commit_t         commit
);
    import ooo_cfg_pkg::*;

    // register table read path
    wire [reg_idx_w-1:0] rs1_idx;
    wire [reg_idx_w-1:0] rs2_idx;
    wire [xlen-1:0]      v1;
    wire [xlen-1:0]      v2;
    wire [rob_id_w-1:0]  q1;
    wire [rob_id_w-1:0]  q2;

    // rob query and allocation
    wire [rob_id_w-1:0]  query_q1;
    wire [rob_id_w-1:0]  query_q2;
    wire                 ready1;
    wire                 ready2;
    wire [xlen-1:0]      data1;
    wire [xlen-1:0]      data2;
    wire                 alloc;
    wire [reg_idx_w-1:0] alloc_rd;
    wire [rob_id_w-1:0]  alloc_id;
    wire                 rob_full;

    dispatcher dispatcher_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .in_valid        (in_valid),
        .in_instr        (in_instr),
        .flush           (flush),
        .alu_cdb         (alu_cdb),
        .mem_cdb         (mem_cdb),
        .rob_full        (rob_full),
        .in_ready        (in_ready),
        .rs1_idx         (rs1_idx),
        .rs2_idx         (rs2_idx),
        .v1              (v1),
        .v2              (v2),
        .q1              (q1),
        .q2              (q2),
        .query_q1        (query_q1),
        .query_q2        (query_q2),
        .ready1          (ready1),
        .ready2          (ready2),
        .data1           (data1),
        .data2           (data2),
        .alloc_id        (alloc_id),
        .alloc           (alloc),
        .alloc_rd        (alloc_rd),
        .rs_issue_valid  (rs_issue_valid),
        .rs_issue        (rs_issue),
        .lsb_issue_valid (lsb_issue_valid),
        .lsb_issue       (lsb_issue)
    );

    reg_status_table reg_status_table_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_idx  (rs1_idx),
        .rs2_idx  (rs2_idx),
        .alloc    (alloc),
        .alloc_rd (alloc_rd),
        .alloc_id (alloc_id),
        .commit   (commit),
        .flush    (flush),
        .v1       (v1),
        .v2       (v2),
        .q1       (q1),
        .q2       (q2)
    );

    rob_tracker rob_tracker_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .alloc    (alloc),
        .alloc_rd (alloc_rd),
        .query_q1 (query_q1),
        .query_q2 (query_q2),
        .alu_cdb  (alu_cdb),
        .mem_cdb  (mem_cdb),
        .flush    (flush),
        .alloc_id (alloc_id),
        .full     (rob_full),
        .ready1   (ready1),
        .data1    (data1),
        .ready2   (ready2),
        .data2    (data2),
        .commit   (commit)
    );

endmodule

`default_nettype wire

// ==== design/dispatch_types_pkg.sv ====
`default_nettype none

package dispatch_types_pkg;

    // one beat from decode
    typedef struct packed {
        logic [ooo_cfg_pkg::opcode_w-1:0]  opcode;
        logic [ooo_cfg_pkg::reg_idx_w-1:0] rd;
        logic [ooo_cfg_pkg::reg_idx_w-1:0] rs1;
        logic [ooo_cfg_pkg::reg_idx_w-1:0] rs2;
        logic [ooo_cfg_pkg::xlen-1:0]      imm;
        logic [ooo_cfg_pkg::xlen-1:0]      pc;
    } decoded_instr_t;

    // q of zero means the matching v is final
    typedef struct packed {
        logic [ooo_cfg_pkg::opcode_w-1:0] opcode;
        logic [ooo_cfg_pkg::xlen-1:0]     v1;
        logic [ooo_cfg_pkg::xlen-1:0]     v2;
        logic [ooo_cfg_pkg::rob_id_w-1:0] q1;
        logic [ooo_cfg_pkg::rob_id_w-1:0] q2;
        logic [ooo_cfg_pkg::xlen-1:0]     imm;
        logic [ooo_cfg_pkg::xlen-1:0]     pc;
        logic [ooo_cfg_pkg::rob_id_w-1:0] rob_id;
    } issue_pkt_t;

    // result broadcast
    typedef struct packed {
        logic                             valid;
        logic [ooo_cfg_pkg::rob_id_w-1:0] rob_id;
        logic [ooo_cfg_pkg::xlen-1:0]     data;
    } cdb_t;

    // retirement write to the register file
    typedef struct packed {
        logic                              valid;
        logic [ooo_cfg_pkg::reg_idx_w-1:0] rd;
        logic [ooo_cfg_pkg::xlen-1:0]      data;
        logic [ooo_cfg_pkg::rob_id_w-1:0]  rob_id;
    } commit_t;

endpackage

`default_nettype wire

// ==== design/dispatcher.sv ====
`timescale 1ns/10ps
`default_nettype none

module dispatcher (
    input  wire                                 clk,
    input  wire                                 rst_n,
    input  wire                                 in_valid,
    input  wire  dispatch_types_pkg::decoded_instr_t in_instr,
    input  wire                                 flush,
    input  wire  dispatch_types_pkg::cdb_t      alu_cdb,
    input  wire  dispatch_types_pkg::cdb_t      mem_cdb,
    input  wire                                 rob_full,
    output logic                                in_ready,
    output logic [ooo_cfg_pkg::reg_idx_w-1:0]   rs1_idx,
    output logic [ooo_cfg_pkg::reg_idx_w-1:0]   rs2_idx,
    input  wire  [ooo_cfg_pkg::xlen-1:0]        v1,
    input  wire  [ooo_cfg_pkg::xlen-1:0]        v2,
    input  wire  [ooo_cfg_pkg::rob_id_w-1:0]    q1,
    input  wire  [ooo_cfg_pkg::rob_id_w-1:0]    q2,
    output logic [ooo_cfg_pkg::rob_id_w-1:0]    query_q1,
    output logic [ooo_cfg_pkg::rob_id_w-1:0]    query_q2,
    input  wire                                 ready1,
    input  wire                                 ready2,
    input  wire  [ooo_cfg_pkg::xlen-1:0]        data1,
    input  wire  [ooo_cfg_pkg::xlen-1:0]        data2,
    input  wire  [ooo_cfg_pkg::rob_id_w-1:0]    alloc_id,
    output logic                                alloc,
    output logic [ooo_cfg_pkg::reg_idx_w-1:0]   alloc_rd,
    output logic                                rs_issue_valid,
    output dispatch_types_pkg::issue_pkt_t      rs_issue,
    output logic                                lsb_issue_valid,
    output dispatch_types_pkg::issue_pkt_t      lsb_issue
);
    import ooo_cfg_pkg::*;
    import dispatch_types_pkg::*;

    logic       is_nop;
    logic       is_mem;
    issue_pkt_t pkt;

    // cdb beats first, then a finished rob entry, then the table as read
    function automatic void resolve(
        input  logic [xlen-1:0]     reg_v,
        input  logic [rob_id_w-1:0] reg_q,
        input  logic                rob_ready,
        input  logic [xlen-1:0]     rob_data,
        input  cdb_t                alu,
        input  cdb_t                mem,
        output logic [xlen-1:0]     v,
        output logic [rob_id_w-1:0] q
    );
        v = reg_v;
        q = reg_q;
        if (reg_q != zero_rob) begin
            if (alu.valid && alu.rob_id == reg_q) begin
                v = alu.data;
                q = zero_rob;
            end else if (mem.valid && mem.rob_id == reg_q) begin
                v = mem.data;
                q = zero_rob;
            end else if (rob_ready) begin
                v = rob_data;
                q = zero_rob;
            end
        end
    endfunction

    assign in_ready = !rob_full && !flush;
    assign is_nop   = (in_instr.opcode == op_nop);
    assign is_mem   = (in_instr.opcode >= op_lb) && (in_instr.opcode <= op_sw);

    // nops are taken off the bus but never allocate
    assign alloc    = in_valid && in_ready && !is_nop;
    assign alloc_rd = in_instr.rd;

    assign rs1_idx  = in_instr.rs1;
    assign rs2_idx  = in_instr.rs2;
    assign query_q1 = q1;
    assign query_q2 = q2;

    always_comb begin
        pkt.opcode = in_instr.opcode;
        pkt.imm    = in_instr.imm;
        pkt.pc     = in_instr.pc;
        pkt.rob_id = alloc_id;
        resolve(v1, q1, ready1, data1, alu_cdb, mem_cdb, pkt.v1, pkt.q1);
        resolve(v2, q2, ready2, data2, alu_cdb, mem_cdb, pkt.v2, pkt.q2);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rs_issue_valid  <= 1'b0;
            lsb_issue_valid <= 1'b0;
        end else begin
            rs_issue_valid  <= alloc && !is_mem;
            lsb_issue_valid <= alloc && is_mem;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc && is_mem) begin
            lsb_issue <= pkt;
        end
        if (alloc && !is_mem) begin
            rs_issue <= pkt;
        end
    end

endmodule

`default_nettype wire

// ==== design/ooo_cfg_pkg.sv ====
`default_nettype none

package ooo_cfg_pkg;

    // datapath and register file
    localparam int xlen      = 32;
    localparam int reg_count = 32;
    localparam int reg_idx_w = 5;

    // reorder buffer, slot 0 reserved as "no producer"
    localparam int rob_depth = 16;
    localparam int rob_id_w  = 4;
    localparam logic [rob_id_w-1:0] zero_rob = '0;

    localparam int opcode_w = 6;

    // alu class
    localparam logic [opcode_w-1:0] op_nop = 6'd0;
    localparam logic [opcode_w-1:0] op_add = 6'd1;
    localparam logic [opcode_w-1:0] op_sub = 6'd2;
    localparam logic [opcode_w-1:0] op_and = 6'd3;
    localparam logic [opcode_w-1:0] op_or  = 6'd4;
    localparam logic [opcode_w-1:0] op_xor = 6'd5;
    localparam logic [opcode_w-1:0] op_slt = 6'd6;
    localparam logic [opcode_w-1:0] op_beq = 6'd7;
    localparam logic [opcode_w-1:0] op_jal = 6'd8;

    // memory class, must stay contiguous from lb to sw
    localparam logic [opcode_w-1:0] op_lb = 6'd9;
    localparam logic [opcode_w-1:0] op_lh = 6'd10;
    localparam logic [opcode_w-1:0] op_lw = 6'd11;
    localparam logic [opcode_w-1:0] op_sb = 6'd12;
    localparam logic [opcode_w-1:0] op_sh = 6'd13;
    localparam logic [opcode_w-1:0] op_sw = 6'd14;

endpackage

`default_nettype wire

// ==== design/reg_status_table.sv ====
`timescale 1ns/10ps
`default_nettype none

module reg_status_table (
    input  wire                                 clk,
    input  wire                                 rst_n,
    input  wire  [ooo_cfg_pkg::reg_idx_w-1:0]   rs1_idx,
    input  wire  [ooo_cfg_pkg::reg_idx_w-1:0]   rs2_idx,
    input  wire                                 alloc,
    input  wire  [ooo_cfg_pkg::reg_idx_w-1:0]   alloc_rd,
    input  wire  [ooo_cfg_pkg::rob_id_w-1:0]    alloc_id,
    input  wire  dispatch_types_pkg::commit_t   commit,
    input  wire                                 flush,
    output logic [ooo_cfg_pkg::xlen-1:0]        v1,
    output logic [ooo_cfg_pkg::xlen-1:0]        v2,
    output logic [ooo_cfg_pkg::rob_id_w-1:0]    q1,
    output logic [ooo_cfg_pkg::rob_id_w-1:0]    q2
);
    import ooo_cfg_pkg::*;

    logic [xlen-1:0]     reg_val [reg_count];
    logic [rob_id_w-1:0] reg_tag [reg_count];

    logic commit_wr;
    logic commit_clr;
    logic alloc_wr;

    // x0 is never written so it keeps value 0 and tag 0
    assign commit_wr  = commit.valid && (commit.rd != '0);
    assign commit_clr = commit_wr && (reg_tag[commit.rd] == commit.rob_id);
    assign alloc_wr   = alloc && (alloc_rd != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < reg_count; i++) begin
                reg_val[i] <= '0;
                reg_tag[i] <= zero_rob;
            end
        end else begin
            // retiring value lands even on a flush edge
            if (commit_wr) begin
                reg_val[commit.rd] <= commit.data;
            end

            if (flush) begin
                for (int i = 0; i < reg_count; i++) begin
                    reg_tag[i] <= zero_rob;
                end
            end else begin
                // a younger producer may already own rd
                if (commit_clr) begin
                    reg_tag[commit.rd] <= zero_rob;
                end
                // new allocation overrides a same-cycle clear
                if (alloc_wr) begin
                    reg_tag[alloc_rd] <= alloc_id;
                end
            end
        end
    end

    // reads see state before this edge
    always_comb begin
        v1 = reg_val[rs1_idx];
        v2 = reg_val[rs2_idx];
        q1 = reg_tag[rs1_idx];
        q2 = reg_tag[rs2_idx];
    end

endmodule

`default_nettype wire

// ==== design/rob_tracker.sv ====
`timescale 1ns/10ps
`default_nettype none

module rob_tracker (
    input  wire                                 clk,
    input  wire                                 rst_n,
    input  wire                                 alloc,
    input  wire  [ooo_cfg_pkg::reg_idx_w-1:0]   alloc_rd,
    input  wire  [ooo_cfg_pkg::rob_id_w-1:0]    query_q1,
    input  wire  [ooo_cfg_pkg::rob_id_w-1:0]    query_q2,
    input  wire  dispatch_types_pkg::cdb_t      alu_cdb,
    input  wire  dispatch_types_pkg::cdb_t      mem_cdb,
    input  wire                                 flush,
    output logic [ooo_cfg_pkg::rob_id_w-1:0]    alloc_id,
    output logic                                full,
    output logic                                ready1,
    output logic [ooo_cfg_pkg::xlen-1:0]        data1,
    output logic                                ready2,
    output logic [ooo_cfg_pkg::xlen-1:0]        data2,
    output dispatch_types_pkg::commit_t         commit
);
    import ooo_cfg_pkg::*;

    localparam logic [rob_id_w-1:0] first_id = rob_id_w'(1);
    localparam logic [rob_id_w-1:0] last_id  = rob_id_w'(rob_depth - 1);

    logic [rob_id_w-1:0] head;
    logic [rob_id_w-1:0] tail;
    logic [rob_id_w-1:0] count;

    logic [rob_depth-1:0] busy;
    logic [rob_depth-1:0] done;
    logic [reg_idx_w-1:0] rd_q   [rob_depth];
    logic [xlen-1:0]      data_q [rob_depth];

    logic commit_now;

    // wrap past slot 0
    function automatic logic [rob_id_w-1:0] next_id(input logic [rob_id_w-1:0] id);
        return (id == last_id) ? first_id : id + 1'b1;
    endfunction

    assign alloc_id   = tail;
    assign full       = (count == last_id);
    assign commit_now = busy[head] && done[head];

    always_comb begin
        commit.valid  = commit_now;
        commit.rd     = rd_q[head];
        commit.data   = data_q[head];
        commit.rob_id = head;
    end

    // slot 0 is never busy, so a zero tag never reads ready
    assign ready1 = busy[query_q1] && done[query_q1];
    assign ready2 = busy[query_q2] && done[query_q2];
    assign data1  = data_q[query_q1];
    assign data2  = data_q[query_q2];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head  <= first_id;
            tail  <= first_id;
            count <= '0;
            busy  <= '0;
            done  <= '0;
        end else if (flush) begin
            head  <= first_id;
            tail  <= first_id;
            count <= '0;
            busy  <= '0;
            done  <= '0;
        end else begin
            if (alloc) begin
                busy[tail] <= 1'b1;
                done[tail] <= 1'b0;
                tail       <= next_id(tail);
            end
            if (alu_cdb.valid && busy[alu_cdb.rob_id]) begin
                done[alu_cdb.rob_id] <= 1'b1;
            end
            if (mem_cdb.valid && busy[mem_cdb.rob_id]) begin
                done[mem_cdb.rob_id] <= 1'b1;
            end
            // retire last so it wins over a stray beat on the head
            if (commit_now) begin
                busy[head] <= 1'b0;
                done[head] <= 1'b0;
                head       <= next_id(head);
            end
            case ({alloc, commit_now})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            rd_q[tail] <= alloc_rd;
        end
        if (alu_cdb.valid) begin
            data_q[alu_cdb.rob_id] <= alu_cdb.data;
        end
        if (mem_cdb.valid) begin
            data_q[mem_cdb.rob_id] <= mem_cdb.data;
        end
    end

endmodule

`default_nettype wire
